//--- router_params.svh
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

//////////////////////////////
// Bus side widths
//////////////////////////////

`define ROUTER_ADDR_W        32
`define ROUTER_DATA_W        32

//////////////////////////////
// Target side widths
//////////////////////////////

`define ROUTER_WORD_ADDR_W   12
`define ROUTER_REG_ADDR_W    3
`define ROUTER_WBEN_W        4

// Region select bits of haddr
`define ROUTER_REG_BIT       15
`define ROUTER_DATA_BIT      14

// Only this htrans code opens an access
`define ROUTER_HTRANS_NONSEQ 2'b10

`endif

//--- bus_pkg.sv
`default_nettype none

`include "router_params.svh"

package bus_pkg;

    typedef logic [`ROUTER_ADDR_W-1:0] haddr_t;
    typedef logic [`ROUTER_DATA_W-1:0] hdata_t;

    // AHB transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = `ROUTER_HTRANS_NONSEQ,
        SEQ    = 2'b11
    } htrans_e;

    // Codes above WORD are served as a full word
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

endpackage

`default_nettype wire

//--- map_pkg.sv
`default_nettype none

`include "router_params.svh"

package map_pkg;

    // Memory region behind each target port
    typedef enum logic [1:0] {
        INST = 2'b00,
        DATA = 2'b01,
        REGS = 2'b10
    } target_e;

    // Core master that wins the next conflict
    typedef enum logic {
        MASTER_IMEM = 1'b0,
        MASTER_DMEM = 1'b1
    } master_e;

    typedef logic [`ROUTER_WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [`ROUTER_REG_ADDR_W-1:0]  reg_addr_t;

    // One enable per byte lane
    typedef logic [`ROUTER_WBEN_W-1:0] wben_t;

endpackage

`default_nettype wire

//--- bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_params.svh"

module bus_decoder (
    input  wire bus_pkg::haddr_t     haddr,
    input  wire bus_pkg::htrans_e    htrans,
    input  wire bus_pkg::hsize_e     hsize,
    input  wire logic                hwrite,
    input  wire bus_pkg::hdata_t     hwdata,
    output logic                     req,
    output map_pkg::target_e         target,
    output map_pkg::word_addr_t      word_addr,
    output map_pkg::reg_addr_t       reg_addr,
    output map_pkg::wben_t           wben,
    output logic                     write,
    output bus_pkg::hdata_t          wdata
);

    assign req = (htrans == bus_pkg::NONSEQ);

    // Register block wins over the RAM select bit
    always_comb begin
        if (haddr[`ROUTER_REG_BIT]) begin
            target = map_pkg::REGS;
        end else if (haddr[`ROUTER_DATA_BIT]) begin
            target = map_pkg::DATA;
        end else begin
            target = map_pkg::INST;
        end
    end

    assign word_addr = haddr[`ROUTER_WORD_ADDR_W+1:2];
    assign reg_addr  = haddr[`ROUTER_REG_ADDR_W-1:0];

    //////////////////////////////
    // Byte lanes
    //////////////////////////////

    always_comb begin
        case (hsize)
            bus_pkg::BYTE: begin
                wben = map_pkg::wben_t'(1) << haddr[1:0];
            end
            bus_pkg::HALF: begin
                // Halfword sits in the low lanes only when aligned to 0
                wben = (haddr[1:0] == 2'b00) ? 4'b0011 : 4'b1100;
            end
            default: begin
                wben = '1;
            end
        endcase
    end

    assign write = hwrite;
    assign wdata = hwdata;

endmodule

`default_nettype wire

//--- target_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module target_arbiter #(
    parameter map_pkg::target_e TARGET      = map_pkg::INST,
    parameter map_pkg::master_e FAVOR_RESET = map_pkg::MASTER_IMEM
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                core_run,
    input  wire logic                spi_req,
    input  wire map_pkg::target_e    spi_target,
    input  wire map_pkg::word_addr_t spi_word_addr,
    input  wire map_pkg::reg_addr_t  spi_reg_addr,
    input  wire map_pkg::wben_t      spi_wben,
    input  wire logic                spi_write,
    input  wire bus_pkg::hdata_t     spi_wdata,
    input  wire logic                imem_req,
    input  wire map_pkg::target_e    imem_target,
    input  wire map_pkg::word_addr_t imem_word_addr,
    input  wire map_pkg::reg_addr_t  imem_reg_addr,
    input  wire map_pkg::wben_t      imem_wben,
    input  wire logic                imem_write,
    input  wire bus_pkg::hdata_t     imem_wdata,
    input  wire logic                dmem_req,
    input  wire map_pkg::target_e    dmem_target,
    input  wire map_pkg::word_addr_t dmem_word_addr,
    input  wire map_pkg::reg_addr_t  dmem_reg_addr,
    input  wire map_pkg::wben_t      dmem_wben,
    input  wire logic                dmem_write,
    input  wire bus_pkg::hdata_t     dmem_wdata,
    output map_pkg::word_addr_t      addr,
    output map_pkg::wben_t           wben,
    output logic                     rwn,
    output bus_pkg::hdata_t          wdata,
    output logic                     grant_imem,
    output logic                     grant_dmem,
    output logic                     lost_imem,
    output logic                     lost_dmem
);

    localparam bit IS_REGS = (TARGET == map_pkg::REGS);

    map_pkg::master_e    favor;
    map_pkg::word_addr_t spi_addr;
    map_pkg::word_addr_t imem_addr;
    map_pkg::word_addr_t dmem_addr;
    logic                spi_hit;
    logic                imem_hit;
    logic                dmem_hit;
    logic                conflict;
    logic                sel_imem;
    logic                sel_dmem;
    map_pkg::word_addr_t nxt_addr;
    map_pkg::wben_t      nxt_wben;
    logic                nxt_rwn;
    bus_pkg::hdata_t     nxt_wdata;

    // Register block is addressed by the low address bits
    assign spi_addr  = IS_REGS ? map_pkg::word_addr_t'(spi_reg_addr) : spi_word_addr;
    assign imem_addr = IS_REGS ? map_pkg::word_addr_t'(imem_reg_addr) : imem_word_addr;
    assign dmem_addr = IS_REGS ? map_pkg::word_addr_t'(dmem_reg_addr) : dmem_word_addr;

    //////////////////////////////
    // Request selection
    //////////////////////////////

    // Loader is heard only in loader mode and only for writes
    assign spi_hit  = !core_run && spi_req && spi_write && (spi_target == TARGET);
    assign imem_hit = core_run && imem_req && (imem_target == TARGET);
    assign dmem_hit = core_run && dmem_req && (dmem_target == TARGET);
    assign conflict = imem_hit && dmem_hit;

    assign sel_imem = imem_hit && (!dmem_hit || favor == map_pkg::MASTER_IMEM);
    assign sel_dmem = dmem_hit && (!imem_hit || favor == map_pkg::MASTER_DMEM);

    always_comb begin
        nxt_addr  = imem_addr;
        nxt_wdata = imem_wdata;
        nxt_wben  = '0;
        nxt_rwn   = 1'b1;
        if (spi_hit) begin
            nxt_addr  = spi_addr;
            nxt_wdata = spi_wdata;
            nxt_wben  = spi_wben;
            nxt_rwn   = 1'b0;
        end else if (sel_imem) begin
            nxt_wben = imem_wben;
            nxt_rwn  = !imem_write;
        end else if (sel_dmem) begin
            nxt_addr  = dmem_addr;
            nxt_wdata = dmem_wdata;
            nxt_wben  = dmem_wben;
            nxt_rwn   = !dmem_write;
        end
    end

    //////////////////////////////
    // Target port and grants
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rwn        <= 1'b1;
            wben       <= '0;
            grant_imem <= 1'b0;
            grant_dmem <= 1'b0;
            lost_imem  <= 1'b0;
            lost_dmem  <= 1'b0;
            favor      <= FAVOR_RESET;
        end else begin
            rwn        <= nxt_rwn;
            wben       <= nxt_wben;
            grant_imem <= sel_imem;
            grant_dmem <= sel_dmem;
            lost_imem  <= conflict && !sel_imem;
            lost_dmem  <= conflict && !sel_dmem;
            if (conflict) begin
                favor <= (favor == map_pkg::MASTER_IMEM) ? map_pkg::MASTER_DMEM
                                                         : map_pkg::MASTER_IMEM;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr  <= nxt_addr;
        wdata <= nxt_wdata;
    end

    assert property (@(posedge clk) disable iff (reset) !(grant_imem && grant_dmem));

    // A refused master always means the other one got the port
    assert property (@(posedge clk) disable iff (reset) lost_imem |-> grant_dmem);
    assert property (@(posedge clk) disable iff (reset) lost_dmem |-> grant_imem);

endmodule

`default_nettype wire

//--- response_router.sv
`timescale 1ns/1ps
`default_nettype none

module response_router (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            core_run,
    input  wire bus_pkg::hdata_t inst_read,
    input  wire bus_pkg::hdata_t data_read,
    input  wire bus_pkg::hdata_t reg_read,
    input  wire logic            inst_grant_imem,
    input  wire logic            inst_grant_dmem,
    input  wire logic            inst_lost_imem,
    input  wire logic            inst_lost_dmem,
    input  wire logic            data_grant_imem,
    input  wire logic            data_grant_dmem,
    input  wire logic            data_lost_imem,
    input  wire logic            data_lost_dmem,
    input  wire logic            reg_grant_imem,
    input  wire logic            reg_grant_dmem,
    input  wire logic            reg_lost_imem,
    input  wire logic            reg_lost_dmem,
    output logic                 spi_hready,
    output logic                 imem_hready,
    output logic                 dmem_hready,
    output bus_pkg::hdata_t      imem_hrdata,
    output bus_pkg::hdata_t      dmem_hrdata
);

    logic             run_q;
    logic             load_q;
    logic             imem_granted;
    logic             dmem_granted;
    map_pkg::target_e imem_src;
    map_pkg::target_e dmem_src;

    function automatic bus_pkg::hdata_t pick_read(input map_pkg::target_e src);
        case (src)
            map_pkg::INST: pick_read = inst_read;
            map_pkg::DATA: pick_read = data_read;
            default:       pick_read = reg_read;
        endcase
    endfunction

    //////////////////////////////
    // Ready levels
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q  <= 1'b0;
            load_q <= 1'b0;
        end else begin
            run_q  <= core_run;
            load_q <= !core_run;
        end
    end

    assign spi_hready  = load_q;
    assign imem_hready = run_q && !(inst_lost_imem || data_lost_imem || reg_lost_imem);
    assign dmem_hready = run_q && !(inst_lost_dmem || data_lost_dmem || reg_lost_dmem);

    //////////////////////////////
    // Read data
    //////////////////////////////

    // Grant pulses say which target served each master this cycle
    assign imem_granted = inst_grant_imem || data_grant_imem || reg_grant_imem;
    assign dmem_granted = inst_grant_dmem || data_grant_dmem || reg_grant_dmem;

    always_comb begin
        imem_src = map_pkg::INST;
        if (data_grant_imem) begin
            imem_src = map_pkg::DATA;
        end else if (reg_grant_imem) begin
            imem_src = map_pkg::REGS;
        end
        dmem_src = map_pkg::INST;
        if (data_grant_dmem) begin
            dmem_src = map_pkg::DATA;
        end else if (reg_grant_dmem) begin
            dmem_src = map_pkg::REGS;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_granted) begin
            imem_hrdata <= pick_read(imem_src);
        end
        if (dmem_granted) begin
            dmem_hrdata <= pick_read(dmem_src);
        end
    end

    // At most one core master is stalled by a conflict
    assert property (@(posedge clk) disable iff (reset)
        (core_run && $past(core_run) && !$past(reset)) |-> (imem_hready || dmem_hready));

endmodule

`default_nettype wire

//--- mem_router.sv
`timescale 1ns/1ps
`default_nettype none

module mem_router (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             core_run,
    input  wire bus_pkg::haddr_t  spi_haddr,
    input  wire bus_pkg::htrans_e spi_htrans,
    input  wire bus_pkg::hsize_e  spi_hsize,
    input  wire logic             spi_hwrite,
    input  wire bus_pkg::hdata_t  spi_hwdata,
    input  wire bus_pkg::haddr_t  imem_haddr,
    input  wire bus_pkg::htrans_e imem_htrans,
    input  wire bus_pkg::hsize_e  imem_hsize,
    input  wire logic             imem_hwrite,
    input  wire bus_pkg::hdata_t  imem_hwdata,
    input  wire bus_pkg::haddr_t  dmem_haddr,
    input  wire bus_pkg::htrans_e dmem_htrans,
    input  wire bus_pkg::hsize_e  dmem_hsize,
    input  wire logic             dmem_hwrite,
    input  wire bus_pkg::hdata_t  dmem_hwdata,
    input  wire bus_pkg::hdata_t  inst_read,
    input  wire bus_pkg::hdata_t  data_read,
    input  wire bus_pkg::hdata_t  reg_read,
    output logic                  spi_hready,
    output logic                  imem_hready,
    output logic                  dmem_hready,
    output bus_pkg::hdata_t       imem_hrdata,
    output bus_pkg::hdata_t       dmem_hrdata,
    output map_pkg::word_addr_t   inst_addr,
    output map_pkg::wben_t        inst_wben,
    output logic                  inst_rwn,
    output bus_pkg::hdata_t       inst_write,
    output map_pkg::word_addr_t   data_addr,
    output map_pkg::wben_t        data_wben,
    output logic                  data_rwn,
    output bus_pkg::hdata_t       data_write,
    output map_pkg::reg_addr_t    reg_addr,
    output map_pkg::wben_t        reg_wben,
    output logic                  reg_rwn,
    output bus_pkg::hdata_t       reg_write
);

    logic                spi_req, imem_req, dmem_req;
    map_pkg::target_e    spi_target, imem_target, dmem_target;
    map_pkg::word_addr_t spi_word_addr, imem_word_addr, dmem_word_addr;
    map_pkg::reg_addr_t  spi_reg_addr, imem_reg_addr, dmem_reg_addr;
    map_pkg::wben_t      spi_wben, imem_wben, dmem_wben;
    logic                spi_write, imem_write, dmem_write;
    bus_pkg::hdata_t     spi_wdata, imem_wdata, dmem_wdata;
    logic                inst_grant_imem, inst_grant_dmem, inst_lost_imem, inst_lost_dmem;
    logic                data_grant_imem, data_grant_dmem, data_lost_imem, data_lost_dmem;
    logic                reg_grant_imem, reg_grant_dmem, reg_lost_imem, reg_lost_dmem;
    map_pkg::word_addr_t reg_word_addr;

    //////////////////////////////
    // Decode
    //////////////////////////////

    bus_decoder u_spi_dec (
        .haddr(spi_haddr), .htrans(spi_htrans), .hsize(spi_hsize),
        .hwrite(spi_hwrite), .hwdata(spi_hwdata),
        .req(spi_req), .target(spi_target), .word_addr(spi_word_addr),
        .reg_addr(spi_reg_addr), .wben(spi_wben), .write(spi_write), .wdata(spi_wdata)
    );

    bus_decoder u_imem_dec (
        .haddr(imem_haddr), .htrans(imem_htrans), .hsize(imem_hsize),
        .hwrite(imem_hwrite), .hwdata(imem_hwdata),
        .req(imem_req), .target(imem_target), .word_addr(imem_word_addr),
        .reg_addr(imem_reg_addr), .wben(imem_wben), .write(imem_write), .wdata(imem_wdata)
    );

    bus_decoder u_dmem_dec (
        .haddr(dmem_haddr), .htrans(dmem_htrans), .hsize(dmem_hsize),
        .hwrite(dmem_hwrite), .hwdata(dmem_hwdata),
        .req(dmem_req), .target(dmem_target), .word_addr(dmem_word_addr),
        .reg_addr(dmem_reg_addr), .wben(dmem_wben), .write(dmem_write), .wdata(dmem_wdata)
    );

    //////////////////////////////
    // Per-target arbitration
    //////////////////////////////

    target_arbiter #(.TARGET(map_pkg::INST), .FAVOR_RESET(map_pkg::MASTER_IMEM)) u_inst_arb (
        .*,
        .addr(inst_addr), .wben(inst_wben), .rwn(inst_rwn), .wdata(inst_write),
        .grant_imem(inst_grant_imem), .grant_dmem(inst_grant_dmem),
        .lost_imem(inst_lost_imem), .lost_dmem(inst_lost_dmem)
    );

    target_arbiter #(.TARGET(map_pkg::DATA), .FAVOR_RESET(map_pkg::MASTER_DMEM)) u_data_arb (
        .*,
        .addr(data_addr), .wben(data_wben), .rwn(data_rwn), .wdata(data_write),
        .grant_imem(data_grant_imem), .grant_dmem(data_grant_dmem),
        .lost_imem(data_lost_imem), .lost_dmem(data_lost_dmem)
    );

    target_arbiter #(.TARGET(map_pkg::REGS), .FAVOR_RESET(map_pkg::MASTER_DMEM)) u_reg_arb (
        .*,
        .addr(reg_word_addr), .wben(reg_wben), .rwn(reg_rwn), .wdata(reg_write),
        .grant_imem(reg_grant_imem), .grant_dmem(reg_grant_dmem),
        .lost_imem(reg_lost_imem), .lost_dmem(reg_lost_dmem)
    );

    // Register arbiter carries the register address zero-extended
    assign reg_addr = reg_word_addr[$bits(map_pkg::reg_addr_t)-1:0];

    response_router u_resp (.*);

endmodule

`default_nettype wire

//--- router_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_params.svh"

module router_tb;

    localparam int IDLE_PORT  = 0;
    localparam int READ_PORT  = 1;
    localparam int WRITE_PORT = 2;

    // Target models answer with their address XOR one of these
    localparam bus_pkg::hdata_t READ_KEY [3] = '{32'h5a5a0000, 32'h3c3c0000, 32'h0f0f0000};

    // kind 0..2 is a target port, 3 the hready levels, 4 and 5 imem and dmem hrdata
    typedef struct {
        int                  due;
        int                  kind;
        int                  mode;
        map_pkg::word_addr_t addr;
        map_pkg::wben_t      wben;
        bus_pkg::hdata_t     data;
    } expect_t;

    logic                clk;
    logic                reset;
    logic                core_run;
    bus_pkg::haddr_t     spi_haddr, imem_haddr, dmem_haddr;
    bus_pkg::htrans_e    spi_htrans, imem_htrans, dmem_htrans;
    bus_pkg::hsize_e     spi_hsize, imem_hsize, dmem_hsize;
    logic                spi_hwrite, imem_hwrite, dmem_hwrite;
    bus_pkg::hdata_t     spi_hwdata, imem_hwdata, dmem_hwdata;
    bus_pkg::hdata_t     inst_read, data_read, reg_read;
    logic                spi_hready, imem_hready, dmem_hready;
    bus_pkg::hdata_t     imem_hrdata, dmem_hrdata;
    map_pkg::word_addr_t inst_addr, data_addr;
    map_pkg::reg_addr_t  reg_addr;
    map_pkg::wben_t      inst_wben, data_wben, reg_wben;
    logic                inst_rwn, data_rwn, reg_rwn;
    bus_pkg::hdata_t     inst_write, data_write, reg_write;

    int                  seed = 49254;
    int                  cyc = 0;
    expect_t             exp_q [$];

    logic                port_on [3];
    int                  port_mode [3];
    map_pkg::word_addr_t port_addr [3];
    map_pkg::wben_t      port_wben [3];
    bus_pkg::hdata_t     port_data [3];
    logic                ready_on;
    logic [2:0]          ready_exp;
    logic                rd_on [2];
    bus_pkg::hdata_t     rd_exp [2];

    map_pkg::word_addr_t got_addr [3];
    map_pkg::wben_t      got_wben [3];
    logic                got_rwn [3];
    bus_pkg::hdata_t     got_data [3];

    mem_router UUT (.*);

    always #50 clk = ~clk;

    // Target models
    assign inst_read = {20'b0, inst_addr} ^ READ_KEY[0];
    assign data_read = {20'b0, data_addr} ^ READ_KEY[1];
    assign reg_read  = {29'b0, reg_addr} ^ READ_KEY[2];

    assign got_addr[0] = inst_addr;
    assign got_addr[1] = data_addr;
    assign got_addr[2] = {9'b0, reg_addr};
    assign got_wben[0] = inst_wben;
    assign got_wben[1] = data_wben;
    assign got_wben[2] = reg_wben;
    assign got_rwn[0]  = inst_rwn;
    assign got_rwn[1]  = data_rwn;
    assign got_rwn[2]  = reg_rwn;
    assign got_data[0] = inst_write;
    assign got_data[1] = data_write;
    assign got_data[2] = reg_write;

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic string target_name(input int t);
        case (t)
            0: return "inst";
            1: return "data";
            default: return "reg";
        endcase
    endfunction

    //////////////////////////////
    // Checks due this cycle
    //////////////////////////////

    // Entries due at this edge are armed for the next falling edge
    always @(posedge clk) begin : load_checks
        expect_t e;
        cyc <= cyc + 1;
        ready_on <= 1'b0;
        rd_on[0] <= 1'b0;
        rd_on[1] <= 1'b0;
        for (int t = 0; t < 3; t++) begin
            port_on[t] <= 1'b0;
        end
        for (int i = exp_q.size() - 1; i >= 0; i--) begin
            e = exp_q[i];
            if (e.due == cyc) begin
                if (e.kind < 3) begin
                    port_on[e.kind]   <= 1'b1;
                    port_mode[e.kind] <= e.mode;
                    port_addr[e.kind] <= e.addr;
                    port_wben[e.kind] <= e.wben;
                    port_data[e.kind] <= e.data;
                end else if (e.kind == 3) begin
                    ready_on  <= 1'b1;
                    ready_exp <= e.wben[2:0];
                end else begin
                    rd_on[e.kind-4]  <= 1'b1;
                    rd_exp[e.kind-4] <= e.data;
                end
                exp_q.delete(i);
            end
        end
    end

    for (genvar t = 0; t < 3; t++) begin : g_port_check
        assert property (@(negedge clk) port_on[t] |->
            got_rwn[t] == (port_mode[t] != WRITE_PORT))
            else flag_mismatch({target_name(t), "_rwn"}, 32'(got_rwn[t]),
                               32'(port_mode[t] != WRITE_PORT));
        assert property (@(negedge clk) port_on[t] |-> got_wben[t] == port_wben[t])
            else flag_mismatch({target_name(t), "_wben"}, 32'(got_wben[t]),
                               32'(port_wben[t]));
        assert property (@(negedge clk) (port_on[t] && port_mode[t] != IDLE_PORT) |->
            got_addr[t] == port_addr[t])
            else flag_mismatch({target_name(t), "_addr"}, 32'(got_addr[t]),
                               32'(port_addr[t]));
        assert property (@(negedge clk) (port_on[t] && port_mode[t] == WRITE_PORT) |->
            got_data[t] == port_data[t])
            else flag_mismatch({target_name(t), "_write"}, got_data[t], port_data[t]);
    end

    assert property (@(negedge clk) ready_on |-> spi_hready == ready_exp[2])
        else flag_mismatch("spi_hready", 32'(spi_hready), 32'(ready_exp[2]));
    assert property (@(negedge clk) ready_on |-> imem_hready == ready_exp[1])
        else flag_mismatch("imem_hready", 32'(imem_hready), 32'(ready_exp[1]));
    assert property (@(negedge clk) ready_on |-> dmem_hready == ready_exp[0])
        else flag_mismatch("dmem_hready", 32'(dmem_hready), 32'(ready_exp[0]));
    assert property (@(negedge clk) rd_on[0] |-> imem_hrdata == rd_exp[0])
        else flag_mismatch("imem_hrdata", imem_hrdata, rd_exp[0]);
    assert property (@(negedge clk) rd_on[1] |-> dmem_hrdata == rd_exp[1])
        else flag_mismatch("dmem_hrdata", dmem_hrdata, rd_exp[1]);

    //////////////////////////////
    // Address decode reference
    //////////////////////////////

    function automatic int region_of(input bus_pkg::haddr_t a);
        if (a[`ROUTER_REG_BIT])
            return 2;
        if (a[`ROUTER_DATA_BIT])
            return 1;
        return 0;
    endfunction

    function automatic map_pkg::word_addr_t port_addr_of(input bus_pkg::haddr_t a);
        if (a[`ROUTER_REG_BIT])
            return {9'b0, a[2:0]};
        return a[13:2];
    endfunction

    function automatic map_pkg::wben_t lanes_of(input bus_pkg::hsize_e sz,
                                                input logic [1:0] low);
        map_pkg::wben_t lanes;
        lanes = '0;
        if (sz == bus_pkg::BYTE)
            lanes[low] = 1'b1;
        else if (sz == bus_pkg::HALF)
            lanes = (low == 2'b00) ? 4'b0011 : 4'b1100;
        else
            lanes = '1;
        return lanes;
    endfunction

    function automatic bus_pkg::haddr_t random_addr(input int region);
        bus_pkg::haddr_t a;
        a = $random(seed);
        a[`ROUTER_REG_BIT] = (region == 2);
        if (region != 2)
            a[`ROUTER_DATA_BIT] = (region == 1);
        return a;
    endfunction

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic queue_expect(input int delay, input int kind, input int mode,
                                input map_pkg::word_addr_t addr, input map_pkg::wben_t wben,
                                input bus_pkg::hdata_t data);
        expect_t e;
        e.due  = cyc + delay;
        e.kind = kind;
        e.mode = mode;
        e.addr = addr;
        e.wben = wben;
        e.data = data;
        exp_q.push_back(e);
    endtask

    // m is 0 for spi, 1 for imem, 2 for dmem
    task automatic expect_access(input int m, input bus_pkg::haddr_t a,
                                 input bus_pkg::hsize_e sz, input logic wr,
                                 input bus_pkg::hdata_t wd, inout logic [2:0] busy);
        int t;
        t = region_of(a);
        busy[t] = 1'b1;
        queue_expect(1, t, wr ? WRITE_PORT : READ_PORT, port_addr_of(a), lanes_of(sz, a[1:0]), wd);
        if (!wr && m != 0)
            queue_expect(2, 3 + m, 0, '0, '0, READ_KEY[t] ^ {20'b0, port_addr_of(a)});
    endtask

    task automatic expect_quiet_ports(input logic [2:0] busy);
        for (int t = 0; t < 3; t++) begin
            if (!busy[t])
                queue_expect(1, t, IDLE_PORT, '0, '0, '0);
        end
    endtask

    task automatic expect_ready(input logic spi, input logic imem, input logic dmem);
        queue_expect(1, 3, 0, '0, {1'b0, spi, imem, dmem}, '0);
    endtask

    task automatic idle_all;
        spi_htrans  <= bus_pkg::IDLE;
        imem_htrans <= bus_pkg::IDLE;
        dmem_htrans <= bus_pkg::IDLE;
    endtask

    task automatic drive_master(input int m, input bus_pkg::haddr_t a,
                                input bus_pkg::hsize_e sz, input logic wr,
                                input bus_pkg::hdata_t wd);
        case (m)
            0: begin
                spi_haddr  <= a;
                spi_htrans <= bus_pkg::NONSEQ;
                spi_hsize  <= sz;
                spi_hwrite <= wr;
                spi_hwdata <= wd;
            end
            1: begin
                imem_haddr  <= a;
                imem_htrans <= bus_pkg::NONSEQ;
                imem_hsize  <= sz;
                imem_hwrite <= wr;
                imem_hwdata <= wd;
            end
            default: begin
                dmem_haddr  <= a;
                dmem_htrans <= bus_pkg::NONSEQ;
                dmem_hsize  <= sz;
                dmem_hwrite <= wr;
                dmem_hwdata <= wd;
            end
        endcase
    endtask

    task automatic wait_for_ready(input int m, input string what);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < 20 && !seen; i++) begin
            @(posedge clk);
            case (m)
                0: seen = spi_hready;
                1: seen = imem_hready;
                default: seen = dmem_hready;
            endcase
        end
        if (!seen)
            abort_on_timeout({what, " never went high"});
    endtask

    task automatic wait_for_checks;
        int left;
        left = 20;
        while (exp_q.size() != 0 && left > 0) begin
            @(posedge clk);
            left--;
        end
        if (exp_q.size() != 0)
            abort_on_timeout("expected results still pending after the last access");
        repeat (2) @(posedge clk);
    endtask

    // Both core masters hit one target and the loser holds its request
    task automatic conflict_run(input int region, input int first);
        bus_pkg::haddr_t ia;
        bus_pkg::haddr_t da;
        bus_pkg::hdata_t dd;
        logic [2:0]      busy;
        int              favored;
        favored = first;
        ia = random_addr(region);
        da = random_addr(region);
        dd = $random(seed);
        for (int k = 0; k < 6; k++) begin
            @(posedge clk);
            busy = '0;
            drive_master(1, ia, bus_pkg::WORD, 1'b0, '0);
            drive_master(2, da, bus_pkg::WORD, 1'b1, dd);
            if (favored == 1) begin
                expect_access(1, ia, bus_pkg::WORD, 1'b0, '0, busy);
                expect_ready(1'b0, 1'b1, 1'b0);
                ia = random_addr(region);
            end else begin
                expect_access(2, da, bus_pkg::WORD, 1'b1, dd, busy);
                expect_ready(1'b0, 1'b0, 1'b1);
                da = random_addr(region);
                dd = $random(seed);
            end
            expect_quiet_ports(busy);
            favored = 3 - favored;
        end
        @(posedge clk);
        idle_all();
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin : stimulus
        bus_pkg::haddr_t a;
        bus_pkg::haddr_t b;
        bus_pkg::hdata_t wd;
        bus_pkg::hsize_e sz;
        logic            wr;
        logic [2:0]      busy;
        int              m;
        int              r_d;
        clk         = 1'b0;
        reset       = 1'b1;
        core_run    = 1'b0;
        spi_haddr   = '0;
        imem_haddr  = '0;
        dmem_haddr  = '0;
        spi_htrans  = bus_pkg::IDLE;
        imem_htrans = bus_pkg::IDLE;
        dmem_htrans = bus_pkg::IDLE;
        spi_hsize   = bus_pkg::WORD;
        imem_hsize  = bus_pkg::WORD;
        dmem_hsize  = bus_pkg::WORD;
        spi_hwrite  = 1'b0;
        imem_hwrite = 1'b0;
        dmem_hwrite = 1'b0;
        spi_hwdata  = '0;
        imem_hwdata = '0;
        dmem_hwdata = '0;

        // Reset values are checked while reset is still held
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i >= 1 && i <= 8) begin
                expect_quiet_ports(3'b000);
                expect_ready(1'b0, 1'b0, 1'b0);
            end
            if (i == 9)
                reset <= 1'b0;
        end

        // Loader writes of each size before a read and a SEQ write that reach no target
        wait_for_ready(0, "spi_hready in loader mode");
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            idle_all();
            busy = '0;
            a  = random_addr(i % 3);
            wd = $random(seed);
            sz = bus_pkg::hsize_e'(3'(i));
            wr = (i != 4);
            drive_master(0, a, sz, wr, wd);
            if (i == 5)
                spi_htrans <= bus_pkg::SEQ;
            if (wr && i != 5)
                expect_access(0, a, sz, 1'b1, wd, busy);
            expect_quiet_ports(busy);
            expect_ready(1'b1, 1'b0, 1'b0);
        end

        @(posedge clk);
        idle_all();
        core_run <= 1'b1;
        wait_for_ready(1, "imem_hready after entering core mode");

        // One core access per cycle
        for (int i = 0; i < 24; i++) begin
            @(posedge clk);
            idle_all();
            busy = '0;
            m  = 1 + int'($unsigned($random(seed)) % 2);
            a  = random_addr(i % 3);
            sz = bus_pkg::hsize_e'(3'($unsigned($random(seed)) % 4));
            wr = 1'($random(seed));
            wd = $random(seed);
            drive_master(m, a, sz, wr, wd);
            expect_access(m, a, sz, wr, wd, busy);
            expect_quiet_ports(busy);
            expect_ready(1'b0, 1'b1, 1'b1);
        end

        // imem and dmem on different targets in the same cycle
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            idle_all();
            busy = '0;
            r_d = (i % 3 + 1 + int'($unsigned($random(seed)) % 2)) % 3;
            a  = random_addr(i % 3);
            b  = random_addr(r_d);
            sz = bus_pkg::hsize_e'(3'($unsigned($random(seed)) % 4));
            wr = 1'($random(seed));
            wd = $random(seed);
            drive_master(1, a, sz, wr, wd);
            drive_master(2, b, bus_pkg::WORD, !wr, ~wd);
            expect_access(1, a, sz, wr, wd, busy);
            expect_access(2, b, bus_pkg::WORD, !wr, ~wd, busy);
            expect_quiet_ports(busy);
            expect_ready(1'b0, 1'b1, 1'b1);
        end

        @(posedge clk);
        idle_all();
        conflict_run(0, 1);
        conflict_run(1, 2);

        wait_for_checks();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
bus_pkg.sv
map_pkg.sv
bus_decoder.sv
target_arbiter.sv
response_router.sv
mem_router.sv
router_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps \
    -f tb.f --top-module router_tb -o router_sim

# The simulator exits non-zero on a failing check, the log decides
./obj_dir/router_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
